// File: Bender.yml
package:
  name: ttc_lite

sources:
  - ttc_pkg.sv
  - ttc_reg_decode.sv
  - ttc_prescaler.sv
  - ttc_count_unit.sv
  - ttc_intr_unit.sv
  - ttc_timer_counter.sv
  - ttc_lite.sv
  - target: test
    files:
      - ttc_lite_tb.sv

// File: ttc_count_unit.sv
// Timer count unit
// 16-bit up/down counter with interval reload, and the
// overflow, interval and match events it raises while counting
`timescale 1ns/10ps
`default_nettype none

module ttc_count_unit import ttc_pkg::*; (
   input  wire logic                 pclk,
   input  wire logic                 rst_n,
   input  wire logic                 tick,
   input  wire cntr_ctrl_t           cntr_ctrl,
   input  wire logic                 cnt_rst,    // Load start value
   input  wire logic [cnt_width-1:0] interval,
   input  wire logic [cnt_width-1:0] match1,
   input  wire logic [cnt_width-1:0] match2,
   input  wire logic [cnt_width-1:0] match3,
   output logic      [cnt_width-1:0] count,
   output intr_t                     events
);

   logic [cnt_width-1:0] cnt_nxt;
   logic                 step;      // Counter moves this cycle

   assign step = tick && !cntr_ctrl.dis;

   // ------------------------------
   // Next count and events
   // ------------------------------
   always_comb begin
      cnt_nxt = count;
      events  = '0;
      if (cnt_rst) begin
         // Start value depends on direction
         cnt_nxt = cntr_ctrl.decrement ? interval : '0;
      end else if (step) begin
         if (!cntr_ctrl.decrement) begin
            if (cntr_ctrl.interval_mode && count == interval) begin
               cnt_nxt         = '0;        // Reload at interval
               events.interval = 1'b1;
            end else if (count == '1) begin
               cnt_nxt         = '0;        // Plain wrap
               events.overflow = 1'b1;
            end else begin
               cnt_nxt = count + 1'b1;
            end
         end else begin
            if (count == '0) begin
               if (cntr_ctrl.interval_mode) begin
                  cnt_nxt         = interval;
                  events.interval = 1'b1;
               end else begin
                  cnt_nxt         = '1;     // Underflow to top
                  events.overflow = 1'b1;
               end
            end else begin
               cnt_nxt = count - 1'b1;
            end
         end
         // Matches fire on the move onto the value
         if (cntr_ctrl.match_en) begin
            events.match[0] = (cnt_nxt == match1);
            events.match[1] = (cnt_nxt == match2);
            events.match[2] = (cnt_nxt == match3);
         end
      end
   end

   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         count <= '0;
      end else begin
         count <= cnt_nxt;
      end
   end

endmodule

`default_nettype wire

// File: ttc_intr_unit.sv
// Timer interrupt unit
// Sticky status bits, clear on read, the enable register
// and the interrupt level of one timer
`timescale 1ns/10ps
`default_nettype none

module ttc_intr_unit import ttc_pkg::*; (
   input  wire logic       pclk,
   input  wire logic       rst_n,
   input  wire intr_t      events,
   input  wire logic       intr_en_wr,
   input  wire logic [5:0] wdata_en,
   input  wire logic       intr_rd,      // Status read, clears it
   output intr_t           intr,
   output intr_t           intr_en,
   output logic            irq
);

   intr_t status_nxt;

   // ------------------------------
   // Status
   // ------------------------------
   always_comb begin
      status_nxt          = intr_rd ? '0 : intr;
      status_nxt          = status_nxt | events;   // Event beats the clear
      status_nxt.reserved = 1'b0;
   end

   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         intr <= '0;
      end else begin
         intr <= status_nxt;
      end
   end

   // ------------------------------
   // Enable
   // ------------------------------
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         intr_en <= '0;
      end else if (intr_en_wr) begin
         intr_en          <= wdata_en;
         intr_en.reserved <= 1'b0;    // Not writable
      end
   end

   // Level follows the status register directly
   assign irq = |(intr & intr_en);

endmodule

`default_nettype wire

// File: ttc_lite.f
ttc_pkg.sv
ttc_reg_decode.sv
ttc_prescaler.sv
ttc_count_unit.sv
ttc_intr_unit.sv
ttc_timer_counter.sv
ttc_lite.sv
ttc_lite_tb.sv

// File: ttc_lite.sv
// Triple timer counter, top level
// APB register decoder in front of three identical timers,
// one interrupt line per timer
`timescale 1ns/10ps
`default_nettype none

module ttc_lite import ttc_pkg::*; (
   input  wire logic                  pclk,
   input  wire logic                  rst_n,
   input  wire logic                  psel,
   input  wire logic                  penable,
   input  wire logic                  pwrite,
   input  wire logic [addr_width-1:0] paddr,
   input  wire logic [data_width-1:0] pwdata,
   output wire logic [data_width-1:0] prdata,
   output wire irq_vec_t              interrupt
);

   // ------------------------------
   // Interconnect
   // ------------------------------
   reg_sel_t    sel [num_timers];    // Strobes per timer
   timer_regs_t regs [num_timers];   // Register views per timer

   ttc_reg_decode u_reg_decode (
      .pclk    (pclk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .regs    (regs),
      .sel     (sel),
      .prdata  (prdata)
   );

   // ------------------------------
   // Timers
   // ------------------------------
   for (genvar i = 0; i < num_timers; i++) begin : g_timer
      ttc_timer_counter u_timer (
         .pclk  (pclk),
         .rst_n (rst_n),
         .sel   (sel[i]),
         .wdata (pwdata[cnt_width-1:0]),   // Registers are 16 bits at most
         .regs  (regs[i]),
         .irq   (interrupt[i])
      );
   end

endmodule

`default_nettype wire

// File: ttc_lite_tb.sv
// Testbench for the triple timer counter
// Walks a table of APB accesses and checks prdata and interrupt
`timescale 1ns/10ps
`default_nettype none

module ttc_lite_tb import ttc_pkg::*; ();

   typedef enum logic [1:0] {op_write, op_read, op_irq, op_idle} op_t;

   typedef struct packed {
      op_t                   op;
      logic [addr_width-1:0] addr;
      logic [data_width-1:0] data;
      logic [data_width-1:0] exp;       // Read data or interrupt vector
      logic [15:0]           wait_cyc;  // Idle cycles after the access
   } entry_t;

   logic                  pclk = 1'b0;
   logic                  rst_n;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [addr_width-1:0] paddr;
   logic [data_width-1:0] pwdata;
   logic [data_width-1:0] prdata;
   irq_vec_t              interrupt;

   entry_t table_q [$];
   int     pass_cnt = 0;
   int     fail_cnt = 0;
   int     cycles   = 0;
   int     limit    = 0;     // Set once the table is built

   ttc_lite dut (
      .pclk      (pclk),
      .rst_n     (rst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   always #50 pclk = ~pclk;   // 100 ns period

   // Run limit from the table length
   always @(posedge pclk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("ERROR: timeout after %0d cycles, table did not complete", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // ------------------------------
   // Helpers
   // ------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Timer idx sits 4 bytes above the previous one
   function automatic logic [addr_width-1:0] map_addr(input logic [addr_width-1:0] base,
                                                      input int idx);
      return base + addr_width'(4 * idx);
   endfunction

   task automatic add_entry(input op_t op, input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] data,
                            input logic [data_width-1:0] exp, input int wait_cyc);
      entry_t e;
      e.op       = op;
      e.addr     = addr;
      e.data     = data;
      e.exp      = exp;
      e.wait_cyc = 16'(wait_cyc);
      table_q.push_back(e);
   endtask

   task automatic check_word(input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] exp,
                             input logic [data_width-1:0] act);
      if (act === exp) begin
         pass_cnt++;
         $display("PASS     prdata @0x%02h = 0x%08h", addr, act);
      end else begin
         fail_cnt++;
         $display("MISMATCH prdata @0x%02h: expected 0x%08h, got 0x%08h", addr, exp, act);
      end
   endtask

   task automatic check_irq(input irq_vec_t exp, input irq_vec_t act);
      if (act === exp) begin
         pass_cnt++;
         $display("PASS     interrupt = 0x%01h", act);
      end else begin
         fail_cnt++;
         $display("MISMATCH interrupt: expected 0x%01h, got 0x%01h", exp, act);
      end
   endtask

   // ------------------------------
   // APB driver, called at edge + 5 ns
   // ------------------------------
   task automatic apb_write(input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] data);
      psel    = 1'b1;                // Setup phase
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge pclk);
      #5 penable = 1'b1;             // Access phase
      @(posedge pclk);               // Write edge
      #5 psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [addr_width-1:0] addr,
                           output logic [data_width-1:0] data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge pclk);
      #5 penable = 1'b1;
      #40 data = prdata;             // Mid access phase
      @(posedge pclk);               // Status clears here
      #5 psel = 1'b0;
      penable = 1'b0;
   endtask

   // ------------------------------
   // Stimulus table
   // ------------------------------
   task automatic build_table();
      logic [addr_width-1:0] all_base [9] = '{clk_ctrl_base, cntr_ctrl_base,
         counter_val_base, interval_base, match1_base, match2_base, match3_base,
         intr_base, intr_en_base};
      logic [addr_width-1:0] rw_base [6] = '{clk_ctrl_base, interval_base,
         match1_base, match2_base, match3_base, intr_en_base};
      logic [data_width-1:0] rw_mask [6] = '{32'h7F, 32'hFFFF, 32'hFFFF, 32'hFFFF,
         32'hFFFF, 32'h1F};            // Field widths, intr_en bit 5 not writable
      logic [31:0]           rng;
      logic [addr_width-1:0] c0;
      int                    run_n;
      rng = 32'd79625;
      c0  = map_addr(cntr_ctrl_base, 0);
      // 1. Reset values, then random read back
      add_entry(op_idle, 0, 0, 0, 2);
      for (int i = 0; i < num_timers; i++)
         for (int j = 0; j < 9; j++)
            add_entry(op_read, map_addr(all_base[j], i), 0,
                      (all_base[j] == cntr_ctrl_base) ? 32'h1 : 32'h0, 0);
      for (int i = 0; i < num_timers; i++) begin
         for (int j = 0; j < 6; j++) begin
            rng = xorshift32(rng);
            add_entry(op_write, map_addr(rw_base[j], i), rng, 0, 0);
            add_entry(op_read, map_addr(rw_base[j], i), 0, rng & rw_mask[j], 0);
         end
      end
      // Timer 0 back to a known state
      add_entry(op_write, map_addr(clk_ctrl_base, 0), 0, 0, 0);
      add_entry(op_write, map_addr(intr_en_base, 0), 0, 0, 0);
      add_entry(op_write, map_addr(interval_base, 0), 0, 0, 0);
      add_entry(op_write, map_addr(match1_base, 0), 32'hFFFF, 0, 0);
      add_entry(op_write, map_addr(match2_base, 0), 32'hFFFF, 0, 0);
      add_entry(op_write, map_addr(match3_base, 0), 32'hFFFF, 0, 0);
      // 2. Start to stop spans wait + 2 edges
      run_n = 8;
      add_entry(op_write, c0, 32'h00, 0, run_n);
      add_entry(op_write, c0, 32'h01, 0, 0);
      add_entry(op_read, counter_val_base, 0, run_n + 2, 0);
      add_entry(op_write, c0, 32'h11, 0, 0);                  // cnt_rst, stays stopped
      add_entry(op_read, counter_val_base, 0, 0, 0);
      add_entry(op_write, map_addr(clk_ctrl_base, 0), 32'h03, 0, 0);   // Divide by 4
      run_n = 18;
      add_entry(op_write, c0, 32'h00, 0, run_n);
      add_entry(op_write, c0, 32'h01, 0, 0);
      add_entry(op_read, counter_val_base, 0, (run_n + 2) / 4, 0);
      add_entry(op_write, map_addr(clk_ctrl_base, 0), 32'h00, 0, 0);
      // 3. Interval mode, interval 5, 13 ticks
      add_entry(op_write, map_addr(interval_base, 0), 32'd5, 0, 0);
      add_entry(op_write, c0, 32'h13, 0, 0);
      add_entry(op_write, c0, 32'h02, 0, 11);
      add_entry(op_write, c0, 32'h03, 0, 0);
      add_entry(op_read, counter_val_base, 0, 13 % 6, 0);
      add_entry(op_read, intr_base, 0, 32'h01, 0);
      add_entry(op_read, intr_base, 0, 32'h00, 0);              // Cleared by first read
      // 4. match2 at 3, five ticks
      add_entry(op_write, map_addr(match2_base, 0), 32'd3, 0, 0);
      add_entry(op_write, c0, 32'h11, 0, 0);
      add_entry(op_write, c0, 32'h08, 0, 3);
      add_entry(op_write, c0, 32'h09, 0, 0);
      add_entry(op_irq, 0, 0, 3'b000, 0);                        // Not enabled yet
      add_entry(op_write, map_addr(intr_en_base, 0), 32'h04, 0, 0);
      add_entry(op_irq, 0, 0, 3'b001, 0);
      add_entry(op_read, intr_base, 0, 32'h04, 0);
      add_entry(op_irq, 0, 0, 3'b000, 0);
      add_entry(op_read, counter_val_base, 0, 5, 0);
      // 5. Count down from interval, six ticks wrap past 0
      add_entry(op_write, c0, 32'h15, 0, 0);
      add_entry(op_read, counter_val_base, 0, 5, 0);
      add_entry(op_write, map_addr(intr_en_base, 0), 32'h10, 0, 0);
      add_entry(op_write, c0, 32'h04, 0, 4);
      add_entry(op_write, c0, 32'h05, 0, 0);
      add_entry(op_irq, 0, 0, 3'b001, 0);
      add_entry(op_read, counter_val_base, 0, 32'hFFFF, 0);
      add_entry(op_read, intr_base, 0, 32'h10, 0);
      add_entry(op_irq, 0, 0, 3'b000, 0);
      add_entry(op_read, map_addr(counter_val_base, 1), 0, 0, 0);    // Never started
      add_entry(op_read, map_addr(counter_val_base, 2), 0, 0, 0);
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      logic [data_width-1:0] rd;
      int                    total;
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      build_table();
      total = 50;
      foreach (table_q[k]) total += int'(table_q[k].wait_cyc) + 4;
      limit = total;
      repeat (3) @(posedge pclk);
      #5 rst_n = 1'b1;
      foreach (table_q[k]) begin
         case (table_q[k].op)
            op_write: apb_write(table_q[k].addr, table_q[k].data);
            op_read: begin
               apb_read(table_q[k].addr, rd);
               check_word(table_q[k].addr, table_q[k].exp, rd);
            end
            op_irq: begin
               #40;
               check_irq(table_q[k].exp[num_timers-1:0], interrupt);
               @(posedge pclk);
               #5;
            end
            default: ;
         endcase
         repeat (table_q[k].wait_cyc) begin
            @(posedge pclk);
            #5;
         end
      end
      $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: ttc_pkg.sv
// Triple timer counter shared definitions
// Widths, register map and the packed field layouts of one timer
`default_nettype none

package ttc_pkg;

   // ------------------------------
   // Widths
   // ------------------------------
   localparam int num_timers = 3;    // Timers behind the bus
   localparam int cnt_width  = 16;   // Counter and compare width
   localparam int addr_width = 8;
   localparam int data_width = 32;
   localparam int div_width  = 16;   // Prescale divider, covers 2^16

   // ------------------------------
   // Register map
   // ------------------------------
   // Timer i sits at base + 4*i
   localparam logic [addr_width-1:0] clk_ctrl_base    = 8'h00;
   localparam logic [addr_width-1:0] cntr_ctrl_base   = 8'h0C;
   localparam logic [addr_width-1:0] counter_val_base = 8'h18;  // Read only
   localparam logic [addr_width-1:0] interval_base    = 8'h24;
   localparam logic [addr_width-1:0] match1_base      = 8'h30;
   localparam logic [addr_width-1:0] match2_base      = 8'h3C;
   localparam logic [addr_width-1:0] match3_base      = 8'h48;
   localparam logic [addr_width-1:0] intr_base        = 8'h54;  // Clear on read
   localparam logic [addr_width-1:0] intr_en_base     = 8'h60;

   // ------------------------------
   // Field layouts
   // ------------------------------
   typedef struct packed {
      logic [1:0] reserved;       // Read back as written
      logic [3:0] prescale_val;   // Tick every 2^(val+1) cycles
      logic       prescale_en;
   } clk_ctrl_t;

   typedef struct packed {
      logic [1:0] reserved;
      logic       cnt_rst;        // Strobe only, reads 0
      logic       match_en;
      logic       decrement;
      logic       interval_mode;
      logic       dis;            // Counter stopped
   } cntr_ctrl_t;

   typedef struct packed {
      logic       reserved;       // Always 0
      logic       overflow;
      logic [2:0] match;          // One per match register
      logic       interval;
   } intr_t;

   // Write strobes of one timer plus the status read strobe
   typedef struct packed {
      logic intr_rd;
      logic intr_en;
      logic match3;
      logic match2;
      logic match1;
      logic interval;
      logic cntr_ctrl;
      logic clk_ctrl;
   } reg_sel_t;

   // Everything one timer shows to the read mux
   typedef struct packed {
      clk_ctrl_t            clk_ctrl;
      cntr_ctrl_t           cntr_ctrl;
      logic [cnt_width-1:0] counter_val;
      logic [cnt_width-1:0] interval;
      logic [cnt_width-1:0] match1;
      logic [cnt_width-1:0] match2;
      logic [cnt_width-1:0] match3;
      intr_t                intr;
      intr_t                intr_en;
   } timer_regs_t;

   typedef logic [num_timers-1:0] irq_vec_t;  // One line per timer

endpackage

`default_nettype wire

// File: ttc_prescaler.sv
// Timer prescaler
// Makes the count tick from the clock control fields, one pulse
// every 2^(prescale_val+1) cycles, or every cycle when disabled
`timescale 1ns/10ps
`default_nettype none

module ttc_prescaler import ttc_pkg::*; (
   input  wire logic      pclk,
   input  wire logic      rst_n,
   input  wire clk_ctrl_t clk_ctrl,
   input  wire logic      clk_ctrl_wr,   // Restarts the divider
   output logic           tick
);

   logic [div_width-1:0] div_q;    // Free running divider
   logic [div_width:0]   span;     // 2^(val+1), one bit wider
   logic [div_width-1:0] mask;     // Divider bits that must be all ones

   assign span = (div_width+1)'(1) << (clk_ctrl.prescale_val + 5'd1);
   assign mask = div_width'(span - (div_width+1)'(1));

   // ------------------------------
   // Divider
   // ------------------------------
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         div_q <= '0;
      end else if (clk_ctrl_wr) begin
         div_q <= '0;                // Phase starts at the write edge
      end else begin
         div_q <= div_q + 1'b1;
      end
   end

   // Low bits all ones marks the last cycle of each period
   always_comb begin
      if (!clk_ctrl.prescale_en) begin
         tick = 1'b1;
      end else begin
         tick = &(div_q | ~mask);
      end
   end

endmodule

`default_nettype wire

// File: ttc_reg_decode.sv
// APB register decoder for the triple timer counter
// Raises per-timer write strobes and the status read strobe,
// and muxes the addressed register onto prdata
`timescale 1ns/10ps
`default_nettype none

module ttc_reg_decode import ttc_pkg::*; (
   input  wire logic                  pclk,
   input  wire logic                  rst_n,
   input  wire logic                  psel,
   input  wire logic                  penable,
   input  wire logic                  pwrite,
   input  wire logic [addr_width-1:0] paddr,
   input  wire timer_regs_t           regs [num_timers],
   output reg_sel_t                   sel [num_timers],
   output logic      [data_width-1:0] prdata
);

   logic                  wr_acc;   // Write access cycle
   logic                  rd_acc;   // Read access cycle
   logic [addr_width-1:0] addr_q;   // Last address seen with psel

   // Address of one register kind for timer idx
   function automatic logic [addr_width-1:0] reg_addr(input logic [addr_width-1:0] base,
                                                       input int idx);
      return base + addr_width'(4 * idx);
   endfunction

   assign wr_acc = psel && penable && pwrite;
   assign rd_acc = psel && penable && !pwrite;

   // ------------------------------
   // Write and clear strobes
   // ------------------------------
   always_comb begin
      for (int i = 0; i < num_timers; i++) begin
         sel[i].clk_ctrl  = wr_acc && (paddr == reg_addr(clk_ctrl_base, i));
         sel[i].cntr_ctrl = wr_acc && (paddr == reg_addr(cntr_ctrl_base, i));
         sel[i].interval  = wr_acc && (paddr == reg_addr(interval_base, i));
         sel[i].match1    = wr_acc && (paddr == reg_addr(match1_base, i));
         sel[i].match2    = wr_acc && (paddr == reg_addr(match2_base, i));
         sel[i].match3    = wr_acc && (paddr == reg_addr(match3_base, i));
         sel[i].intr_en   = wr_acc && (paddr == reg_addr(intr_en_base, i));
         // Status clears at the end of the access cycle
         sel[i].intr_rd   = rd_acc && (paddr == reg_addr(intr_base, i));
      end
   end

   // Address held from the setup phase, stable for the access phase
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         addr_q <= '0;
      end else if (psel) begin
         addr_q <= paddr;
      end
   end

   // ------------------------------
   // Read mux
   // ------------------------------
   always_comb begin
      prdata = '0;                              // Unmapped reads 0
      if (psel && !pwrite) begin
         for (int i = 0; i < num_timers; i++) begin
            case (addr_q)
               reg_addr(clk_ctrl_base, i):    prdata = data_width'(regs[i].clk_ctrl);
               reg_addr(cntr_ctrl_base, i):   prdata = data_width'(regs[i].cntr_ctrl);
               reg_addr(counter_val_base, i): prdata = data_width'(regs[i].counter_val);
               reg_addr(interval_base, i):    prdata = data_width'(regs[i].interval);
               reg_addr(match1_base, i):      prdata = data_width'(regs[i].match1);
               reg_addr(match2_base, i):      prdata = data_width'(regs[i].match2);
               reg_addr(match3_base, i):      prdata = data_width'(regs[i].match3);
               reg_addr(intr_base, i):        prdata = data_width'(regs[i].intr);
               reg_addr(intr_en_base, i):     prdata = data_width'(regs[i].intr_en);
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: ttc_timer_counter.sv
// One timer of the triple timer counter
// Holds the control, interval and match registers and
// connects the prescaler, count unit and interrupt unit
`timescale 1ns/10ps
`default_nettype none

module ttc_timer_counter import ttc_pkg::*; (
   input  wire logic                 pclk,
   input  wire logic                 rst_n,
   input  wire reg_sel_t             sel,
   input  wire logic [cnt_width-1:0] wdata,
   output timer_regs_t               regs,
   output logic                      irq
);

   clk_ctrl_t            clk_ctrl_q;
   cntr_ctrl_t           cntr_ctrl_q;
   cntr_ctrl_t           wr_ctrl;     // Control word on the bus
   cntr_ctrl_t           ctrl_eff;    // Control seen by the counter
   logic [cnt_width-1:0] interval_q;
   logic [cnt_width-1:0] match1_q;
   logic [cnt_width-1:0] match2_q;
   logic [cnt_width-1:0] match3_q;
   logic [cnt_width-1:0] count;
   logic                 cnt_rst;
   logic                 tick;
   intr_t                events;
   intr_t                intr;
   intr_t                intr_en;

   assign wr_ctrl = wdata[$bits(cntr_ctrl_t)-1:0];
   assign cnt_rst = sel.cntr_ctrl && wr_ctrl.cnt_rst;

   // Mode bits act from their write edge, dis only from the next one
   always_comb begin
      ctrl_eff = cntr_ctrl_q;
      if (sel.cntr_ctrl) begin
         ctrl_eff     = wr_ctrl;
         ctrl_eff.dis = cntr_ctrl_q.dis;
      end
   end

   // ------------------------------
   // Registers
   // ------------------------------
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         clk_ctrl_q  <= '0;
         cntr_ctrl_q <= '{dis: 1'b1, default: '0};  // Stopped out of reset
         interval_q  <= '0;
         match1_q    <= '0;
         match2_q    <= '0;
         match3_q    <= '0;
      end else begin
         if (sel.clk_ctrl) clk_ctrl_q <= wdata[$bits(clk_ctrl_t)-1:0];
         if (sel.cntr_ctrl) begin
            cntr_ctrl_q         <= wr_ctrl;
            cntr_ctrl_q.cnt_rst <= 1'b0;             // Strobe, never held
         end
         if (sel.interval) interval_q <= wdata;
         if (sel.match1)   match1_q   <= wdata;
         if (sel.match2)   match2_q   <= wdata;
         if (sel.match3)   match3_q   <= wdata;
      end
   end

   ttc_prescaler u_prescaler (
      .pclk        (pclk),
      .rst_n       (rst_n),
      .clk_ctrl    (clk_ctrl_q),
      .clk_ctrl_wr (sel.clk_ctrl),
      .tick        (tick)
   );

   ttc_count_unit u_count_unit (
      .pclk      (pclk),
      .rst_n     (rst_n),
      .tick      (tick),
      .cntr_ctrl (ctrl_eff),
      .cnt_rst   (cnt_rst),
      .interval  (interval_q),
      .match1    (match1_q),
      .match2    (match2_q),
      .match3    (match3_q),
      .count     (count),
      .events    (events)
   );

   ttc_intr_unit u_intr_unit (
      .pclk       (pclk),
      .rst_n      (rst_n),
      .events     (events),
      .intr_en_wr (sel.intr_en),
      .wdata_en   (wdata[5:0]),
      .intr_rd    (sel.intr_rd),
      .intr       (intr),
      .intr_en    (intr_en),
      .irq        (irq)
   );

   // Register view for the read mux
   assign regs = '{clk_ctrl:    clk_ctrl_q,
                   cntr_ctrl:   cntr_ctrl_q,
                   counter_val: count,
                   interval:    interval_q,
                   match1:      match1_q,
                   match2:      match2_q,
                   match3:      match3_q,
                   intr:        intr,
                   intr_en:     intr_en};

endmodule

`default_nettype wire
